// File: include/modbus_config.svh
`ifndef MODBUS_CONFIG_SVH
`define MODBUS_CONFIG_SVH

// own station byte
`define MODBUS_STATION_ADDR 8'h37

// wishbone bank bases
`define HOLDING_OFFSET 24'hA00000
`define INPUT_OFFSET 24'hB00000

// highest start + quantity
`define REG_LIMIT 'hFFFF
`define MAX_READ_QTY 125

`define WB_ADDR_W 24
`define WB_DATA_W 16

`endif

// File: logic/modbusPkg.sv
`include "modbus_config.svh"

package modbusPkg;

    typedef enum logic [7:0] {
        readHolding = 8'h03,
        readInput   = 8'h04
    } funcCode;

    typedef enum logic [7:0] {
        none            = 8'h00,
        illegalFunction = 8'h01,
        illegalAddress  = 8'h02,
        illegalValue    = 8'h03
    } excCode;

    typedef enum logic [3:0] {
        psStation, psFunction, psAddrHi, psAddrLo, psQtyHi, psQtyLo,
        psCrcLo, psCrcHi, psIgnore
    } parseState;

    typedef enum logic [3:0] {
        bsIdle, bsStation, bsFunction, bsExcCode, bsByteCount, bsFetch,
        bsDataHi, bsDataLo, bsCrcLo, bsCrcHi
    } buildState;

    typedef struct packed {
        logic [7:0]            func;  // raw byte that may be unsupported
        excCode                exc;
        logic [`WB_ADDR_W-1:0] addr;  // already in bank
        logic [6:0]            qty;
    } request;

endpackage

// File: logic/wbPkg.sv
`include "modbus_config.svh"

package wbPkg;

    typedef struct packed {
        logic [`WB_ADDR_W-1:0] adr;
        logic                  stb;  // one cycle per word
    } wbCmd;

    typedef struct packed {
        logic [`WB_DATA_W-1:0] dat;
        logic                  done;  // one cycle after ack
    } wbResult;

endpackage

// File: logic/crc16.sv
`timescale 1ns/1ps

module crc16 (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  logic        en,
    input  logic [7:0]  data,
    output logic [15:0] value
);
    logic [15:0] next;

    // reflected poly stepped one bit at a time
    always_comb begin
        next = value ^ {8'h00, data};
        for (int i = 0; i < 8; i++) begin
            if (next[0]) begin
                next = (next >> 1) ^ 16'hA001;
            end else begin
                next = next >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            value <= 16'hFFFF;
        end else if (en) begin
            value <= next;
        end
    end

endmodule

// File: logic/requestParser.sv
`timescale 1ns/1ps
`include "modbus_config.svh"

module requestParser (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        rxData,
    input  logic              rxValid,
    input  logic              rxParityError,
    input  logic              rxSilence,
    input  logic              busy,
    output logic              rxReq,
    output logic              reqValid,
    output modbusPkg::request req
);
    modbusPkg::parseState  state;
    modbusPkg::parseState  nextState;
    logic                  fire;
    logic                  take;
    logic [15:0]           startAddr;
    logic [7:0]            qtyHi;
    logic [15:0]           qtyFull;
    logic [16:0]           span;
    logic                  isRead;
    logic                  qtyBad;
    logic                  addrBad;
    logic [`WB_ADDR_W-1:0] bank;

    assign take = rxValid && !rxParityError && !rxSilence;
    assign qtyFull = {qtyHi, rxData};
    assign span = {1'b0, startAddr} + {1'b0, qtyFull};
    assign isRead = rxData == modbusPkg::readHolding || rxData == modbusPkg::readInput;
    assign qtyBad = qtyFull == 16'd0 || qtyFull > 16'(`MAX_READ_QTY);
    assign addrBad = span > 17'(`REG_LIMIT);
    assign bank = (req.func == modbusPkg::readInput) ? `INPUT_OFFSET : `HOLDING_OFFSET;

    always_comb begin
        nextState = state;
        fire = 1'b0;
        if (rxSilence) begin
            nextState = modbusPkg::psStation;  // frame gap
        end else if (rxValid && state != modbusPkg::psIgnore) begin
            if (rxParityError) begin
                nextState = modbusPkg::psIgnore;
            end else begin
                case (state)
                    modbusPkg::psStation: begin
                        if (rxData == `MODBUS_STATION_ADDR) begin
                            nextState = modbusPkg::psFunction;
                        end else begin
                            nextState = modbusPkg::psIgnore;  // not for us
                        end
                    end
                    modbusPkg::psFunction: begin
                        if (isRead) begin
                            nextState = modbusPkg::psAddrHi;
                        end else begin
                            nextState = modbusPkg::psIgnore;
                            fire = 1'b1;
                        end
                    end
                    modbusPkg::psAddrHi: nextState = modbusPkg::psAddrLo;
                    modbusPkg::psAddrLo: nextState = modbusPkg::psQtyHi;
                    modbusPkg::psQtyHi: nextState = modbusPkg::psQtyLo;
                    modbusPkg::psQtyLo: begin
                        if (qtyBad || addrBad) begin
                            nextState = modbusPkg::psIgnore;
                            fire = 1'b1;
                        end else begin
                            nextState = modbusPkg::psCrcLo;
                        end
                    end
                    modbusPkg::psCrcLo: nextState = modbusPkg::psCrcHi;
                    modbusPkg::psCrcHi: begin
                        nextState = modbusPkg::psStation;
                        fire = 1'b1;
                    end
                    default: nextState = modbusPkg::psIgnore;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= modbusPkg::psStation;
            reqValid <= 1'b0;
            rxReq <= 1'b0;
        end else begin
            state <= nextState;
            reqValid <= fire && !busy;  // dropped while replying
            rxReq <= rxValid && state != modbusPkg::psIgnore;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            case (state)
                modbusPkg::psFunction: begin
                    req.func <= rxData;
                    if (isRead) begin
                        req.exc <= modbusPkg::none;
                    end else begin
                        req.exc <= modbusPkg::illegalFunction;
                    end
                end
                modbusPkg::psAddrHi: startAddr[15:8] <= rxData;
                modbusPkg::psAddrLo: startAddr[7:0] <= rxData;
                modbusPkg::psQtyHi: qtyHi <= rxData;
                modbusPkg::psQtyLo: begin
                    req.qty <= rxData[6:0];
                    req.addr <= bank + {{(`WB_ADDR_W-16){1'b0}}, startAddr};
                    if (qtyBad) begin
                        req.exc <= modbusPkg::illegalValue;  // quantity checked first
                    end else if (addrBad) begin
                        req.exc <= modbusPkg::illegalAddress;
                    end else begin
                        req.exc <= modbusPkg::none;
                    end
                end
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) reqValid |=> !reqValid)
        else $error("reqValid high on consecutive cycles");

endmodule

// File: logic/wbReader.sv
`timescale 1ns/1ps
`include "modbus_config.svh"

module wbReader (
    input  logic                  clk,
    input  logic                  rst,
    input  wbPkg::wbCmd           cmd,
    input  logic [`WB_DATA_W-1:0] wbDatIn,
    input  logic                  wbAck,
    output wbPkg::wbResult        result,
    output logic [`WB_ADDR_W-1:0] wbAdr,
    output logic                  wbCyc,
    output logic                  wbStb,
    output logic                  wbWe
);
    logic                  done;
    logic                  start;
    logic [`WB_DATA_W-1:0] dat;

    assign start = cmd.stb && !wbCyc;
    assign result = '{dat: dat, done: done};
    assign wbWe = 1'b0;  // read only master

    always_ff @(posedge clk) begin
        if (rst) begin
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                wbCyc <= 1'b1;
                wbStb <= 1'b1;
            end else if (wbCyc && wbAck) begin
                wbCyc <= 1'b0;
                wbStb <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wbAdr <= cmd.adr;
        end
        if (wbCyc && wbAck) begin
            dat <= wbDatIn;
        end
    end

    // the builder only issues a command while the bus is idle
    assert property (@(posedge clk) disable iff (rst) cmd.stb |-> !wbCyc)
        else $error("read command issued while a wishbone cycle is open");

endmodule

// File: logic/responseBuilder.sv
`timescale 1ns/1ps
`include "modbus_config.svh"

module responseBuilder (
    input  logic              clk,
    input  logic              rst,
    input  logic              reqValid,
    input  modbusPkg::request req,
    input  logic              fifoAck,
    input  wbPkg::wbResult    result,
    input  logic [15:0]       crcValue,
    output logic              busy,
    output logic              fifoReq,
    output logic [7:0]        fifoData,
    output wbPkg::wbCmd       cmd,
    output logic              crcClear,
    output logic              crcEn
);
    modbusPkg::buildState  state;
    modbusPkg::excCode     excReg;
    logic [7:0]            funcReg;
    logic [6:0]            qtyReg;
    logic [6:0]            wordsLeft;
    logic [`WB_ADDR_W-1:0] adrReg;
    logic [`WB_DATA_W-1:0] word;
    logic                  cmdStb;
    logic                  isExc;
    logic                  inCrc;
    logic                  start;

    assign isExc = excReg != modbusPkg::none;
    assign busy = state != modbusPkg::bsIdle;
    assign start = !busy && reqValid;
    assign fifoReq = busy && state != modbusPkg::bsFetch;
    assign inCrc = state == modbusPkg::bsCrcLo || state == modbusPkg::bsCrcHi;
    assign crcClear = start;
    assign crcEn = fifoReq && fifoAck && !inCrc;  // crc follows consumed bytes
    assign cmd = '{adr: adrReg, stb: cmdStb};

    always_comb begin
        case (state)
            modbusPkg::bsStation: fifoData = `MODBUS_STATION_ADDR;
            modbusPkg::bsFunction: fifoData = isExc ? {1'b1, funcReg[6:0]} : funcReg;
            modbusPkg::bsExcCode: fifoData = excReg;
            modbusPkg::bsByteCount: fifoData = {qtyReg, 1'b0};
            modbusPkg::bsDataHi: fifoData = word[`WB_DATA_W-1 -: 8];
            modbusPkg::bsDataLo: fifoData = word[7:0];
            modbusPkg::bsCrcLo: fifoData = crcValue[7:0];  // crc sent low byte first
            modbusPkg::bsCrcHi: fifoData = crcValue[15:8];
            default: fifoData = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= modbusPkg::bsIdle;
            cmdStb <= 1'b0;
        end else begin
            cmdStb <= 1'b0;
            case (state)
                modbusPkg::bsIdle: begin
                    if (reqValid) begin
                        state <= modbusPkg::bsStation;
                    end
                end
                modbusPkg::bsStation: begin
                    if (fifoAck) begin
                        state <= modbusPkg::bsFunction;
                    end
                end
                modbusPkg::bsFunction: begin
                    if (fifoAck && isExc) begin
                        state <= modbusPkg::bsExcCode;
                    end else if (fifoAck) begin
                        state <= modbusPkg::bsByteCount;
                    end
                end
                modbusPkg::bsExcCode: begin
                    if (fifoAck) begin
                        state <= modbusPkg::bsCrcLo;
                    end
                end
                modbusPkg::bsByteCount: begin
                    if (fifoAck) begin
                        state <= modbusPkg::bsFetch;
                        cmdStb <= 1'b1;
                    end
                end
                modbusPkg::bsFetch: begin
                    if (result.done) begin
                        state <= modbusPkg::bsDataHi;
                    end
                end
                modbusPkg::bsDataHi: begin
                    if (fifoAck) begin
                        state <= modbusPkg::bsDataLo;
                    end
                end
                modbusPkg::bsDataLo: begin
                    if (fifoAck && wordsLeft == 7'd0) begin
                        state <= modbusPkg::bsCrcLo;
                    end else if (fifoAck) begin
                        state <= modbusPkg::bsFetch;  // next word
                        cmdStb <= 1'b1;
                    end
                end
                modbusPkg::bsCrcLo: begin
                    if (fifoAck) begin
                        state <= modbusPkg::bsCrcHi;
                    end
                end
                modbusPkg::bsCrcHi: begin
                    if (fifoAck) begin
                        state <= modbusPkg::bsIdle;
                    end
                end
                default: state <= modbusPkg::bsIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            funcReg <= req.func;
            excReg <= req.exc;
            qtyReg <= req.qty;
            wordsLeft <= req.qty;
            adrReg <= req.addr;
        end else if (state == modbusPkg::bsFetch && result.done) begin
            word <= result.dat;
            wordsLeft <= wordsLeft - 7'd1;
            adrReg <= adrReg + `WB_ADDR_W'(1);
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        fifoReq && !fifoAck |=> fifoReq && $stable(fifoData))
        else $error("fifo byte changed before ack");

endmodule

// File: logic/modbusTop.sv
`timescale 1ns/1ps
`include "modbus_config.svh"

module modbusTop (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            rxData,
    input  logic                  rxValid,
    input  logic                  rxParityError,
    input  logic                  rxSilence,
    output logic                  rxReq,
    output logic                  fifoReq,
    output logic [7:0]            fifoData,
    input  logic                  fifoAck,
    output logic [`WB_ADDR_W-1:0] wbAdr,
    output logic                  wbCyc,
    output logic                  wbStb,
    output logic                  wbWe,
    input  logic [`WB_DATA_W-1:0] wbDatIn,
    input  logic                  wbAck
);
    logic              reqValid;
    logic              busy;
    logic              crcClear;
    logic              crcEn;
    logic [15:0]       crcValue;
    modbusPkg::request req;
    wbPkg::wbCmd       cmd;
    wbPkg::wbResult    result;

    requestParser u_requestParser (
        .clk           (clk),
        .rst           (rst),
        .rxData        (rxData),
        .rxValid       (rxValid),
        .rxParityError (rxParityError),
        .rxSilence     (rxSilence),
        .busy          (busy),
        .rxReq         (rxReq),
        .reqValid      (reqValid),
        .req           (req)
    );

    responseBuilder u_responseBuilder (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .req      (req),
        .fifoAck  (fifoAck),
        .result   (result),
        .crcValue (crcValue),
        .busy     (busy),
        .fifoReq  (fifoReq),
        .fifoData (fifoData),
        .cmd      (cmd),
        .crcClear (crcClear),
        .crcEn    (crcEn)
    );

    wbReader u_wbReader (
        .clk     (clk),
        .rst     (rst),
        .cmd     (cmd),
        .wbDatIn (wbDatIn),
        .wbAck   (wbAck),
        .result  (result),
        .wbAdr   (wbAdr),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbWe    (wbWe)
    );

    // crc runs over the bytes as they leave
    crc16 u_crc16 (
        .clk   (clk),
        .rst   (rst),
        .clear (crcClear),
        .en    (crcEn),
        .data  (fifoData),
        .value (crcValue)
    );

endmodule

// File: verification/modbusTb.sv
`timescale 1ns/1ps
`include "modbus_config.svh"

module modbusTb;
    logic                  clk;
    logic                  rst;
    logic [7:0]            rxData;
    logic                  rxValid;
    logic                  rxParityError;
    logic                  rxSilence;
    logic                  rxReq;
    logic                  fifoReq;
    logic [7:0]            fifoData;
    logic                  fifoAck;
    logic [`WB_ADDR_W-1:0] wbAdr;
    logic                  wbCyc;
    logic                  wbStb;
    logic                  wbWe;
    logic [`WB_DATA_W-1:0] wbDatIn;
    logic                  wbAck;

    logic [31:0]           lfsr = 32'h645e6811;
    logic [7:0]            expFrame [0:255];
    logic [7:0]            txBuf [0:7];
    logic [7:0]            expHead;
    logic [15:0]           expCrc;
    logic [15:0]           txCrc;
    logic [`WB_ADDR_W-1:0] adrBase;
    logic [`WB_ADDR_W-1:0] expAdr;
    logic                  quiet;  // no response allowed
    logic                  rxLive;  // byte the parser should still take
    int                    expLen;
    int                    txLen;
    int                    expWords;
    int                    frameBase;
    int                    ackBase;
    int                    rxCount = 0;
    int                    ackCount = 0;
    int                    errors = 0;
    int                    tests = 0;
    int                    failed = 0;

    modbusTop u_modbusTop (
        .clk           (clk),
        .rst           (rst),
        .rxData        (rxData),
        .rxValid       (rxValid),
        .rxParityError (rxParityError),
        .rxSilence     (rxSilence),
        .rxReq         (rxReq),
        .fifoReq       (fifoReq),
        .fifoData      (fifoData),
        .fifoAck       (fifoAck),
        .wbAdr         (wbAdr),
        .wbCyc         (wbCyc),
        .wbStb         (wbStb),
        .wbWe          (wbWe),
        .wbDatIn       (wbDatIn),
        .wbAck         (wbAck)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [15:0] crcStep(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        c = crc ^ {8'h00, b};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ 16'hA001;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    function automatic logic [15:0] clipStart(input logic [15:0] start, input logic [15:0] qty);
        if (32'(start) + 32'(qty) > 32'hFFFF) begin
            return 16'hFFFF - qty;
        end
        return start;
    endfunction

    assign expHead = expFrame[8'(rxCount - frameBase)];
    assign expAdr = adrBase + 24'(ackCount - ackBase);

    always @(posedge clk) begin
        if (fifoReq && fifoAck) begin
            rxCount <= rxCount + 1;
        end
        if (wbCyc && wbAck) begin
            ackCount <= ackCount + 1;
        end
    end

    // wishbone slave and fifo sink with random wait states
    initial begin
        int wbWait;
        int fifoWait;
        wbAck = 1'b0;
        wbDatIn = '0;
        fifoAck = 1'b0;
        wbWait = int'(randBits(2));
        fifoWait = int'(randBits(2));
        forever begin
            @(posedge clk);
            #2;
            if (wbAck) begin
                wbAck = 1'b0;
            end else if (wbCyc && wbStb && wbWait > 0) begin
                wbWait--;
            end else if (wbCyc && wbStb) begin
                wbAck = 1'b1;
                wbDatIn = wbAdr[15:0] ^ 16'h5A5A;
                wbWait = int'(randBits(2));
            end
            if (fifoAck) begin
                fifoAck = 1'b0;
            end else if (fifoReq && fifoWait > 0) begin
                fifoWait--;
            end else if (fifoReq) begin
                fifoAck = 1'b1;
                fifoWait = int'(randBits(2));
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        fifoReq && fifoAck |-> rxCount - frameBase < expLen && fifoData == expHead)
        else begin
            $display("** Error at %0t ns: response byte %0d is %02h, expected %02h", $time,
                $sampled(rxCount - frameBase), $sampled(fifoData), $sampled(expHead));
            errors = errors + 1;
        end

    assert property (@(posedge clk) disable iff (rst) quiet |-> !fifoReq)
        else begin
            $display("a response was started for a frame that must be ignored");
            errors = errors + 1;
        end

    assert property (@(posedge clk) disable iff (rst) !wbWe)
        else begin
            $display("wishbone write enable went high");
            errors = errors + 1;
        end

    assert property (@(posedge clk) disable iff (rst) wbStb == wbCyc)
        else begin
            $display("wishbone strobe and cycle did not rise and fall together");
            errors = errors + 1;
        end

    assert property (@(posedge clk) disable iff (rst) rxReq == $past(rxValid && rxLive))
        else begin
            $display("** Error at %0t ns: rxReq is %b, expected %b", $time,
                $sampled(rxReq), !$sampled(rxReq));
            errors = errors + 1;
        end

    assert property (@(posedge clk) disable iff (rst) wbCyc && wbAck |-> wbAdr == expAdr)
        else begin
            $display("** Error at %0t ns: wishbone address %06h, expected %06h", $time,
                $sampled(wbAdr), $sampled(expAdr));
            errors = errors + 1;
        end

    task automatic pushExp(input logic [7:0] b);
        expFrame[expLen[7:0]] = b;
        expCrc = crcStep(expCrc, b);
        expLen++;
    endtask

    task automatic pushTx(input logic [7:0] b);
        txBuf[txLen[2:0]] = b;
        txCrc = crcStep(txCrc, b);
        txLen++;
    endtask

    task automatic expectFrame(input logic [7:0] func, input logic [7:0] exc,
                               input logic [15:0] start, input logic [15:0] qty,
                               input logic [`WB_ADDR_W-1:0] bank);
        logic [`WB_ADDR_W-1:0] addr;
        logic [15:0]           w;
        logic [15:0]           crc;
        frameBase = rxCount;
        ackBase = ackCount;
        adrBase = bank + 24'(start);
        expLen = 0;
        expCrc = 16'hFFFF;
        expWords = 0;
        pushExp(`MODBUS_STATION_ADDR);
        if (exc != 8'h00) begin
            pushExp(func | 8'h80);
            pushExp(exc);
        end else begin
            expWords = int'(qty);
            pushExp(func);
            pushExp(8'(qty * 16'd2));
            for (int i = 0; i < expWords; i++) begin
                addr = adrBase + 24'(i);
                w = addr[15:0] ^ 16'h5A5A;  // model data
                pushExp(w[15:8]);
                pushExp(w[7:0]);
            end
        end
        crc = expCrc;
        pushExp(crc[7:0]);
        pushExp(crc[15:8]);
    endtask

    task automatic buildRequest(input logic [7:0] station, input logic [7:0] func,
                                input logic [15:0] start, input logic [15:0] qty);
        logic [15:0] crc;
        txLen = 0;
        txCrc = 16'hFFFF;
        pushTx(station);
        pushTx(func);
        pushTx(start[15:8]);
        pushTx(start[7:0]);
        pushTx(qty[15:8]);
        pushTx(qty[7:0]);
        crc = txCrc;
        pushTx(crc[7:0]);
        pushTx(crc[15:8]);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic sendByte(input logic [7:0] b, input logic parityError, input logic live);
        rxData = b;
        rxValid = 1'b1;
        rxParityError = parityError;
        rxLive = live;
        idleCycles(1);
        rxValid = 1'b0;
        rxParityError = 1'b0;
        rxLive = 1'b0;
        idleCycles(1);
    endtask

    task automatic sendFrame(input int badIdx, input int liveCount);
        for (int i = 0; i < txLen; i++) begin
            sendByte(txBuf[i[2:0]], i == badIdx, i < liveCount);
        end
    endtask

    task automatic sendSilence();
        rxSilence = 1'b1;
        idleCycles(1);
        rxSilence = 1'b0;
    endtask

    task automatic waitResponse(input int limit);
        int cycles;
        cycles = 0;
        while (rxCount - frameBase < expLen && cycles < limit) begin
            idleCycles(1);
            cycles++;
        end
        if (rxCount - frameBase < expLen) begin
            $display("timeout: response stalled after %0d of %0d bytes",
                rxCount - frameBase, expLen);
            errors++;
        end
        idleCycles(4);  // catch trailing bytes
        assert (rxCount - frameBase == expLen) else begin
            $display("** Error at %0t ns: %0d response bytes, expected %0d", $time,
                rxCount - frameBase, expLen);
            errors++;
        end
        assert (ackCount - ackBase == expWords) else begin
            $display("** Error at %0t ns: %0d bus reads, expected %0d", $time,
                ackCount - ackBase, expWords);
            errors++;
        end
    endtask

    task automatic doRead(input logic [7:0] func, input logic [15:0] start,
                          input logic [15:0] qty);
        logic [7:0]            exc;
        logic [`WB_ADDR_W-1:0] bank;
        int                    live;
        if (func != 8'h03 && func != 8'h04) begin
            exc = 8'h01;
        end else if (qty == 0 || qty > `MAX_READ_QTY) begin
            exc = 8'h03;
        end else if (32'(start) + 32'(qty) > `REG_LIMIT) begin
            exc = 8'h02;
        end else begin
            exc = 8'h00;
        end
        // bytes after the one that reveals an exception are ignored
        if (exc == 8'h01) begin
            live = 2;
        end else if (exc != 8'h00) begin
            live = 6;
        end else begin
            live = 8;
        end
        bank = (func == 8'h04) ? `INPUT_OFFSET : `HOLDING_OFFSET;
        expectFrame(func, exc, start, qty, bank);
        buildRequest(`MODBUS_STATION_ADDR, func, start, qty);
        sendFrame(-1, live);
        sendSilence();
        waitResponse(6000);
    endtask

    task automatic reportTest(input string name, input int errBefore);
        tests++;
        if (errors == errBefore) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: failed", tests, name);
        end
    endtask

    initial begin
        int          errBefore;
        logic [15:0] qty;
        logic [15:0] start;
        rst = 1'b1;
        rxData = 8'h00;
        rxValid = 1'b0;
        rxParityError = 1'b0;
        rxSilence = 1'b0;
        rxLive = 1'b0;
        quiet = 1'b0;
        expLen = 0;
        expWords = 0;
        frameBase = 0;
        ackBase = 0;
        adrBase = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        idleCycles(2);

        errBefore = errors;
        qty = 16'(1 + randBits(7) % 125);
        start = clipStart(16'(randBits(16)), qty);
        doRead(8'h03, start, qty);
        reportTest("read holding registers", errBefore);

        errBefore = errors;
        qty = 16'(1 + randBits(7) % 125);
        start = clipStart(16'(randBits(16)), qty);
        doRead(8'h04, start, qty);
        reportTest("read input registers", errBefore);

        errBefore = errors;
        doRead(8'h06, 16'h0001, 16'h0001);
        reportTest("unsupported function", errBefore);

        errBefore = errors;
        doRead(8'h03, 16'h0010, 16'd0);
        doRead(8'h04, 16'h0010, 16'd126);
        qty = 16'(1 + randBits(7) % 125);
        doRead(8'h03, 16'hFFFF - qty + 16'd1, qty);  // ends one past the limit
        reportTest("quantity and address exceptions", errBefore);

        errBefore = errors;
        quiet = 1'b1;
        buildRequest(8'h12, 8'h03, 16'h0020, 16'd4);
        sendFrame(-1, 1);
        idleCycles(20);
        sendSilence();
        buildRequest(`MODBUS_STATION_ADDR, 8'h03, 16'h0020, 16'd4);
        sendFrame(2, 3);
        idleCycles(20);
        sendSilence();
        quiet = 1'b0;
        doRead(8'h03, 16'h0020, 16'd4);
        reportTest("foreign station and parity error", errBefore);

        errBefore = errors;
        start = clipStart(16'(randBits(16)), 16'd125);
        doRead(8'h03, start, 16'd125);
        reportTest("full read under back-pressure", errBefore);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
logic/modbusPkg.sv
logic/wbPkg.sv
logic/crc16.sv
logic/requestParser.sv
logic/wbReader.sv
logic/responseBuilder.sv
logic/modbusTop.sv
verification/modbusTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module modbusTb -f all.f -o simv

# the log decides the result, so a simulator stop still reaches the search
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
